// File: files.f
+incdir+rtl
rtl/leaf_pkg.sv
rtl/leaf_fifo.sv
rtl/leaf_depacketizer.sv
rtl/leaf_packetizer.sv
rtl/leaf_interface.sv
rtl/user_kernel.sv
rtl/leaf_top.sv
test/leaf_top_sva.sv
test/leaf_top_tb.sv

// File: run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing --assert -j 0 --top-module leaf_top_tb -f files.f \
    > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vleaf_top_tb > sim.log 2>&1
cat sim.log
grep -q "Test FAILED" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a verdict"; exit 1; }
exit 0

// File: test/leaf_top_tb.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_top_tb;
    import leaf_pkg::*;

    localparam leaf_id_t   LEAF_ID       = 5'd3;
    localparam logic [1:0] K_CFG         = 2'd0;
    localparam logic [1:0] K_DATA        = 2'd1;
    localparam logic [1:0] K_FOREIGN     = 2'd2;   // Addressed to the next leaf
    localparam logic [1:0] K_NOVALID     = 2'd3;   // Valid bit low
    localparam int         DRAIN_TIMEOUT = 4000;

    typedef struct packed {
        logic [1:0] kind;
        port_id_t   port;
        logic [7:0] cnt;     // Packets sent for the row
        logic       rnd;     // Payloads from $urandom instead of word + k
        payload_t   word;
        logic [2:0] idx;     // Config fields, used by K_CFG rows only
        leaf_id_t   dleaf;
        port_id_t   dport;
        logic [7:0] rs;      // Resend cycles once the row is sent
        logic       hit;     // Words reach the kernel
    } row_t;

    logic     clk;
    logic     rst_n;
    logic     resend;
    packet_t  din_leaf_bft2interface;
    packet_t  dout_leaf_interface2bft;
    row_t     rows [$];
    payload_t exp_q [`LEAF_NUM_OUT][$];
    tag_t     exp_tag [`LEAF_NUM_OUT];
    logic     cfg_set [`LEAF_NUM_OUT];
    leaf_id_t cfg_leaf [`LEAF_NUM_OUT];
    port_id_t cfg_port [`LEAF_NUM_OUT];
    int       err_cnt;

    leaf_top #(
        .LEAF_ID(LEAF_ID)
    ) i_dut (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .din_leaf_bft2interface (din_leaf_bft2interface),
        .dout_leaf_interface2bft(dout_leaf_interface2bft),
        .resend                 (resend)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_value(input string sig, input logic [63:0] want, input logic [63:0] got);
        err_cnt++;
        $display("FAIL time=%0t signal=%s expected=0x%0h actual=0x%0h", $time, sig, want, got);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first mismatch");
    endtask

    task automatic fail_msg(input string what);
        err_cnt++;
        $display("Error at time %0t: %s", $time, what);
        $display("Test FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    function automatic void add_row(input logic [1:0] kind, input port_id_t port,
                                    input logic [7:0] cnt, input logic rnd, input payload_t word,
                                    input logic [2:0] idx, input leaf_id_t dleaf,
                                    input port_id_t dport, input logic [7:0] rs, input logic hit);
        row_t r;
        r = '{kind, port, cnt, rnd, word, idx, dleaf, dport, rs, hit};
        rows.push_back(r);
    endfunction

    function automatic packet_t make_packet(input logic valid, input leaf_id_t leaf,
                                            input port_id_t port, input payload_t data);
        packet_t p;
        p = '0;
        p[`LEAF_VALID_BIT]                       = valid;
        p[`LEAF_DST_LEAF_MSB:`LEAF_DST_LEAF_LSB] = leaf;
        p[`LEAF_DST_PORT_MSB:`LEAF_DST_PORT_LSB] = port;
        p[`LEAF_PAYLOAD_MSB:`LEAF_PAYLOAD_LSB]   = data;
        return p;
    endfunction

    // Three words per input word, input 1 feeds streams 1 to 3 and input 2 feeds 4 to 6
    task automatic expect_words(input port_id_t port, input payload_t x);
        if (port == 4'd1) begin
            exp_q[0].push_back(x);
            exp_q[1].push_back(x + 32'd1);
            exp_q[2].push_back(~x);
        end else begin
            exp_q[3].push_back(x);
            exp_q[4].push_back({x[15:0], x[31:16]});
            exp_q[5].push_back(x << 1);
        end
    endtask

    task automatic apply_row(input row_t r);
        payload_t w;
        for (int k = 0; k < int'(r.cnt); k++) begin
            w = r.rnd ? $urandom : r.word + 32'(k);
            @(negedge clk);
            case (r.kind)
                K_CFG: begin
                    din_leaf_bft2interface = make_packet(1'b1, LEAF_ID, 4'd0,
                                                         {19'd0, r.dport, r.dleaf, 1'b0, r.idx});
                    cfg_set[r.idx - 3'd1]  = 1'b1;
                    cfg_leaf[r.idx - 3'd1] = r.dleaf;
                    cfg_port[r.idx - 3'd1] = r.dport;
                end
                K_DATA:    din_leaf_bft2interface = make_packet(1'b1, LEAF_ID, r.port, w);
                K_FOREIGN: din_leaf_bft2interface = make_packet(1'b1, LEAF_ID + 5'd1, r.port, w);
                default:   din_leaf_bft2interface = make_packet(1'b0, LEAF_ID, r.port, w);
            endcase
            if (r.hit) begin
                expect_words(r.port, w);
            end
            @(negedge clk);
            din_leaf_bft2interface = '0;
            repeat (3) @(negedge clk);   // Five cycles per packet keep the input queues short
        end
        if (r.rs != 8'd0) begin
            resend = 1'b1;
            repeat (int'(r.rs)) @(negedge clk);
            resend = 1'b0;
        end
    endtask

    task automatic check_packet(input packet_t p);
        int s;
        s = -1;
        for (int i = 0; i < `LEAF_NUM_OUT; i++) begin
            if (cfg_set[i] && cfg_leaf[i] == p[`LEAF_DST_LEAF_MSB:`LEAF_DST_LEAF_LSB] &&
                cfg_port[i] == p[`LEAF_DST_PORT_MSB:`LEAF_DST_PORT_LSB]) begin
                s = i;
            end
        end
        if (s < 0) begin
            fail_msg("packet sent to a destination that is not configured");
        end else if (exp_q[s].size() == 0) begin
            fail_msg($sformatf("extra packet on stream %0d", s + 1));
        end else begin
            assert (p[`LEAF_PAYLOAD_MSB:`LEAF_PAYLOAD_LSB] == exp_q[s][0])
                else fail_value($sformatf("dout_leaf_interface2bft payload, stream %0d", s + 1),
                                64'(exp_q[s][0]), 64'(p[`LEAF_PAYLOAD_MSB:`LEAF_PAYLOAD_LSB]));
            assert (p[`LEAF_TAG_MSB:`LEAF_TAG_LSB] == exp_tag[s])
                else fail_value($sformatf("dout_leaf_interface2bft tag, stream %0d", s + 1),
                                64'(exp_tag[s]), 64'(p[`LEAF_TAG_MSB:`LEAF_TAG_LSB]));
            void'(exp_q[s].pop_front());
            exp_tag[s] = exp_tag[s] + 7'd1;
        end
    endtask

    task automatic wait_drain();
        int cycles;
        int pending;
        cycles  = 0;
        pending = 1;
        while (pending != 0) begin
            @(negedge clk);
            pending = 0;
            for (int i = 0; i < `LEAF_NUM_OUT; i++) begin
                pending += exp_q[i].size();
            end
            cycles++;
            if (cycles > DRAIN_TIMEOUT) begin
                fail_msg($sformatf("timeout, %0d expected packets never arrived", pending));
            end
        end
    endtask

    // The output register updates after this sample, resend is stable since the falling edge
    always @(posedge clk) begin
        if (rst_n === 1'b1) begin
            if (resend || !dout_leaf_interface2bft[`LEAF_VALID_BIT]) begin
                assert (dout_leaf_interface2bft == '0)
                    else fail_value("dout_leaf_interface2bft", 64'(0), 64'(dout_leaf_interface2bft));
            end else begin
                check_packet(dout_leaf_interface2bft);
            end
        end
    end

    initial begin
        rst_n                  = 1'b0;
        resend                 = 1'b0;
        din_leaf_bft2interface = '0;
        err_cnt                = 0;
        void'($urandom(32'ha970));
        for (int i = 0; i < `LEAF_NUM_OUT; i++) begin
            cfg_set[i] = 1'b0;
            exp_tag[i] = '0;
        end
        // kind       port   cnt     rnd   word           idx   dleaf  dport  rs     hit
        add_row(K_CFG,     4'd0,  8'd1,   1'b0, 32'h0,         3'd1, 5'd10, 4'd2,  8'd0,  1'b0);
        add_row(K_CFG,     4'd0,  8'd1,   1'b0, 32'h0,         3'd2, 5'd11, 4'd3,  8'd0,  1'b0);
        add_row(K_CFG,     4'd0,  8'd1,   1'b0, 32'h0,         3'd3, 5'd3,  4'd1,  8'd0,  1'b0);
        add_row(K_DATA,    4'd2,  8'd2,   1'b0, 32'h1234_5678, 3'd0, 5'd0,  4'd0,  8'd0,  1'b1);
        add_row(K_DATA,    4'd1,  8'd3,   1'b0, 32'h0000_0001, 3'd0, 5'd0,  4'd0,  8'd0,  1'b1);
        add_row(K_FOREIGN, 4'd1,  8'd2,   1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd0,  1'b0);
        add_row(K_DATA,    4'd3,  8'd1,   1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd0,  1'b0);
        add_row(K_DATA,    4'd15, 8'd1,   1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd0,  1'b0);
        add_row(K_NOVALID, 4'd2,  8'd2,   1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd0,  1'b0);
        add_row(K_CFG,     4'd0,  8'd1,   1'b0, 32'h0,         3'd4, 5'd31, 4'd7,  8'd0,  1'b0);
        add_row(K_CFG,     4'd0,  8'd1,   1'b0, 32'h0,         3'd5, 5'd0,  4'd0,  8'd0,  1'b0);
        add_row(K_CFG,     4'd0,  8'd1,   1'b0, 32'h0,         3'd6, 5'd17, 4'd15, 8'd0,  1'b0);
        add_row(K_DATA,    4'd2,  8'd4,   1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd12, 1'b1);
        add_row(K_DATA,    4'd1,  8'd130, 1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd0,  1'b1);
        add_row(K_DATA,    4'd2,  8'd20,  1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd30, 1'b1);
        add_row(K_FOREIGN, 4'd2,  8'd3,   1'b1, 32'h0,         3'd0, 5'd0,  4'd0,  8'd0,  1'b0);
        add_row(K_DATA,    4'd1,  8'd5,   1'b0, 32'hffff_fffe, 3'd0, 5'd0,  4'd0,  8'd5,  1'b1);

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        repeat (20) @(negedge clk);   // Idle, the monitor expects a silent output
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end
        wait_drain();
        repeat (60) @(negedge clk);   // Any late packet is an extra one
        if (err_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: test/leaf_top_sva.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_top_sva (
    input logic                                   clk,
    input logic                                   rst_n,
    input logic                                   resend,
    input leaf_pkg::packet_t                      dout_leaf_interface2bft,
    input leaf_pkg::payload_t [`LEAF_NUM_IN-1:0]  dout_leaf_interface2user,
    input logic [`LEAF_NUM_IN-1:0]                vld_interface2user,
    input logic [`LEAF_NUM_IN-1:0]                ack_user2interface,
    input leaf_pkg::payload_t [`LEAF_NUM_OUT-1:0] din_leaf_user2interface,
    input logic [`LEAF_NUM_OUT-1:0]               vld_user2interface,
    input logic [`LEAF_NUM_OUT-1:0]               ack_interface2user
);

    a_resend_quiet: assert property (@(posedge clk) resend |-> dout_leaf_interface2bft == '0)
        else $error("Network output not zero during resend");

    // Covers every reset cycle after the first edge and the cycle after release
    a_reset_quiet: assert property (@(posedge clk) !rst_n |=> dout_leaf_interface2bft == '0)
        else $error("Network output not zero around reset");

    for (genvar i = 0; i < `LEAF_NUM_IN; i++) begin : g_in
        a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
            vld_interface2user[i] && !ack_user2interface[i]
            |=> vld_interface2user[i] && $stable(dout_leaf_interface2user[i]))
            else $error("Input stream %0d changed before ack", i + 1);
        a_in_ack: assert property (@(posedge clk) disable iff (!rst_n)
            ack_user2interface[i] |-> vld_interface2user[i])
            else $error("Ack on input stream %0d without vld", i + 1);
    end

    for (genvar i = 0; i < `LEAF_NUM_OUT; i++) begin : g_out
        a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
            vld_user2interface[i] && !ack_interface2user[i]
            |=> vld_user2interface[i] && $stable(din_leaf_user2interface[i]))
            else $error("Output stream %0d changed before ack", i + 1);
    end

endmodule

bind leaf_top leaf_top_sva i_leaf_top_sva (
    .clk                     (clk),
    .rst_n                   (rst_n),
    .resend                  (resend),
    .dout_leaf_interface2bft (dout_leaf_interface2bft),
    .dout_leaf_interface2user(dout_leaf_interface2user),
    .vld_interface2user      (vld_interface2user),
    .ack_user2interface      (ack_user2interface),
    .din_leaf_user2interface (din_leaf_user2interface),
    .vld_user2interface      (vld_user2interface),
    .ack_interface2user      (ack_interface2user)
);

// File: rtl/leaf_top.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_top #(
    parameter leaf_pkg::leaf_id_t LEAF_ID = 5'd3
) (
    input  logic              clk,
    input  logic              rst_n,
    input  leaf_pkg::packet_t din_leaf_bft2interface,
    output leaf_pkg::packet_t dout_leaf_interface2bft,
    input  logic              resend
);
    import leaf_pkg::*;

    payload_t [`LEAF_NUM_IN-1:0]  dout_leaf_interface2user;
    logic [`LEAF_NUM_IN-1:0]      vld_interface2user;
    logic [`LEAF_NUM_IN-1:0]      ack_user2interface;
    payload_t [`LEAF_NUM_OUT-1:0] din_leaf_user2interface;
    logic [`LEAF_NUM_OUT-1:0]     vld_user2interface;
    logic [`LEAF_NUM_OUT-1:0]     ack_interface2user;

    leaf_interface #(
        .LEAF_ID(LEAF_ID)
    ) i_leaf_interface (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din_leaf_bft2interface  (din_leaf_bft2interface),
        .dout_leaf_interface2bft (dout_leaf_interface2bft),
        .resend                  (resend),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user      (vld_interface2user),
        .ack_user2interface      (ack_user2interface),
        .din_leaf_user2interface (din_leaf_user2interface),
        .vld_user2interface      (vld_user2interface),
        .ack_interface2user      (ack_interface2user)
    );

    user_kernel i_user_kernel (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user      (vld_interface2user),
        .ack_user2interface      (ack_user2interface),
        .din_leaf_user2interface (din_leaf_user2interface),
        .vld_user2interface      (vld_user2interface),
        .ack_interface2user      (ack_interface2user)
    );

endmodule

// File: rtl/user_kernel.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module user_kernel (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  leaf_pkg::payload_t [`LEAF_NUM_IN-1:0]  dout_leaf_interface2user,
    input  logic [`LEAF_NUM_IN-1:0]                 vld_interface2user,
    output logic [`LEAF_NUM_IN-1:0]                 ack_user2interface,
    output leaf_pkg::payload_t [`LEAF_NUM_OUT-1:0] din_leaf_user2interface,
    output logic [`LEAF_NUM_OUT-1:0]                vld_user2interface,
    input  logic [`LEAF_NUM_OUT-1:0]                ack_interface2user
);
    import leaf_pkg::*;

    kernel_state_t state;
    kernel_state_t state_nxt;
    logic          src;        // Input served last, 0 for input 1
    logic          in_sel;
    logic          take;
    logic          done;
    logic          emit_en;
    logic [1:0]    stage;
    logic [2:0]    cur_idx;
    logic [2:0]    emit_idx;
    payload_t      word;
    payload_t      emit_word;

    function automatic payload_t derive(input logic side, input logic [1:0] k, input payload_t x);
        payload_t r;
        case ({side, k})
            3'b000:  r = x;
            3'b001:  r = x + 1'b1;
            3'b010:  r = ~x;
            3'b100:  r = x;
            3'b101:  r = {x[15:0], x[31:16]};
            default: r = x << 1;
        endcase
        return r;
    endfunction

    always_comb begin
        take   = (state == IDLE) && (|vld_interface2user);
        // Alternate when both inputs wait, otherwise take whichever is valid
        in_sel = !(vld_interface2user[0] && (!vld_interface2user[1] || src));
        ack_user2interface = '0;
        if (take) begin
            ack_user2interface[in_sel] = 1'b1;
        end

        case (state)
            EMIT_B:  stage = 2'd1;
            EMIT_C:  stage = 2'd2;
            default: stage = 2'd0;
        endcase
        cur_idx = (src ? 3'd3 : 3'd0) + {1'b0, stage};
        done    = (state != IDLE) && ack_interface2user[cur_idx];
        emit_en = take || (done && (state != EMIT_C));

        if (take) begin
            emit_idx  = in_sel ? 3'd3 : 3'd0;
            emit_word = derive(in_sel, 2'd0, dout_leaf_interface2user[in_sel]);
        end else begin
            emit_idx  = cur_idx + 1'b1;
            emit_word = derive(src, stage + 1'b1, word);
        end

        state_nxt = state;
        case (state)
            IDLE:    if (take) state_nxt = EMIT_A;
            EMIT_A:  if (done) state_nxt = EMIT_B;
            EMIT_B:  if (done) state_nxt = EMIT_C;
            default: if (done) state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state              <= IDLE;
            src                <= 1'b1;   // Input 1 goes first
            vld_user2interface <= '0;
        end else begin
            state <= state_nxt;
            if (take) begin
                src <= in_sel;
            end
            if (done) begin
                vld_user2interface[cur_idx] <= 1'b0;
            end
            if (emit_en) begin
                vld_user2interface[emit_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            word <= dout_leaf_interface2user[in_sel];
        end
        if (emit_en) begin
            din_leaf_user2interface[emit_idx] <= emit_word;
        end
    end

endmodule

// File: rtl/leaf_interface.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_interface #(
    parameter leaf_pkg::leaf_id_t LEAF_ID = 5'd3
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  leaf_pkg::packet_t                       din_leaf_bft2interface,
    output leaf_pkg::packet_t                       dout_leaf_interface2bft,
    input  logic                                    resend,
    output leaf_pkg::payload_t [`LEAF_NUM_IN-1:0]  dout_leaf_interface2user,
    output logic [`LEAF_NUM_IN-1:0]                 vld_interface2user,
    input  logic [`LEAF_NUM_IN-1:0]                 ack_user2interface,
    input  leaf_pkg::payload_t [`LEAF_NUM_OUT-1:0] din_leaf_user2interface,
    input  logic [`LEAF_NUM_OUT-1:0]                vld_user2interface,
    output logic [`LEAF_NUM_OUT-1:0]                ack_interface2user
);
    import leaf_pkg::*;

    logic                          cfg_we;
    logic [`LEAF_CFG_IDX_BITS-1:0] cfg_index;
    leaf_id_t                      cfg_leaf;
    port_id_t                      cfg_port;
    packet_t                       dout_pkt;

    leaf_depacketizer #(
        .LEAF_ID(LEAF_ID)
    ) i_depacketizer (
        .clk                     (clk),
        .rst_n                   (rst_n),
        .din                     (din_leaf_bft2interface),
        .ack_user2interface      (ack_user2interface),
        .dout_leaf_interface2user(dout_leaf_interface2user),
        .vld_interface2user      (vld_interface2user),
        .cfg_we                  (cfg_we),
        .cfg_index               (cfg_index),
        .cfg_leaf                (cfg_leaf),
        .cfg_port                (cfg_port)
    );

    leaf_packetizer i_packetizer (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .cfg_we                 (cfg_we),
        .cfg_index              (cfg_index),
        .cfg_leaf               (cfg_leaf),
        .cfg_port               (cfg_port),
        .din_leaf_user2interface(din_leaf_user2interface),
        .vld_user2interface     (vld_user2interface),
        .ack_interface2user     (ack_interface2user),
        .resend                 (resend),
        .dout                   (dout_pkt)
    );

    // The network asks for silence while it replays its own traffic
    assign dout_leaf_interface2bft = resend ? '0 : dout_pkt;

endmodule

// File: rtl/leaf_packetizer.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_packetizer (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    cfg_we,
    input  logic [`LEAF_CFG_IDX_BITS-1:0]           cfg_index,
    input  leaf_pkg::leaf_id_t                      cfg_leaf,
    input  leaf_pkg::port_id_t                      cfg_port,
    input  leaf_pkg::payload_t [`LEAF_NUM_OUT-1:0] din_leaf_user2interface,
    input  logic [`LEAF_NUM_OUT-1:0]                vld_user2interface,
    output logic [`LEAF_NUM_OUT-1:0]                ack_interface2user,
    input  logic                                    resend,
    output leaf_pkg::packet_t                       dout
);
    import leaf_pkg::*;

    leaf_id_t                       dst_leaf [`LEAF_NUM_OUT];
    port_id_t                       dst_port [`LEAF_NUM_OUT];
    logic [`LEAF_NUM_OUT-1:0]       dst_ok;
    tag_t                           tags [`LEAF_NUM_OUT];
    payload_t                       q_data [`LEAF_NUM_OUT];
    logic [`LEAF_NUM_OUT-1:0]       q_full;
    logic [`LEAF_NUM_OUT-1:0]       q_empty;
    logic [`LEAF_NUM_OUT-1:0]       q_pop;
    logic [`LEAF_NUM_OUT-1:0]       eligible;
    logic [`LEAF_CFG_IDX_BITS-1:0]  cfg_slot;
    logic                           cfg_hit;
    logic [2:0]                     rr_ptr;
    logic [2:0]                     sel;
    logic [3:0]                     scan_sum;
    logic                           found;
    logic                           send;
    packet_t                        pkt;

    assign cfg_slot = cfg_index - 1'b1;   // Table index 1 maps to stream 0
    assign cfg_hit  = cfg_we && (cfg_index != '0) && (cfg_index <= `LEAF_NUM_OUT);

    for (genvar i = 0; i < `LEAF_NUM_OUT; i++) begin : g_out
        assign ack_interface2user[i] = vld_user2interface[i] && !q_full[i];
        assign eligible[i]           = !q_empty[i] && dst_ok[i];
        assign q_pop[i]              = send && (sel == 3'(i));

        leaf_fifo #(
            .DEPTH(`LEAF_FIFO_DEPTH)
        ) i_out_fifo (
            .clk    (clk),
            .rst_n  (rst_n),
            .wr_en  (ack_interface2user[i]),
            .wr_data(din_leaf_user2interface[i]),
            .full   (q_full[i]),
            .rd_en  (q_pop[i]),
            .rd_data(q_data[i]),
            .empty  (q_empty[i])
        );
    end

    // First ready stream at or after the round-robin pointer
    always_comb begin
        found    = 1'b0;
        sel      = '0;
        scan_sum = '0;
        for (int k = 0; k < `LEAF_NUM_OUT; k++) begin
            scan_sum = {1'b0, rr_ptr} + 4'(k);
            if (scan_sum >= 4'(`LEAF_NUM_OUT)) begin
                scan_sum = scan_sum - 4'(`LEAF_NUM_OUT);
            end
            if (!found && eligible[scan_sum[2:0]]) begin
                found = 1'b1;
                sel   = scan_sum[2:0];
            end
        end
    end

    assign send = found && !resend;

    always_comb begin
        pkt = '0;
        pkt[`LEAF_VALID_BIT]                         = 1'b1;
        pkt[`LEAF_DST_LEAF_MSB:`LEAF_DST_LEAF_LSB]   = dst_leaf[sel];
        pkt[`LEAF_DST_PORT_MSB:`LEAF_DST_PORT_LSB]   = dst_port[sel];
        pkt[`LEAF_TAG_MSB:`LEAF_TAG_LSB]             = tags[sel];
        pkt[`LEAF_PAYLOAD_MSB:`LEAF_PAYLOAD_LSB]     = q_data[sel];
    end

    always_ff @(posedge clk) begin
        if (cfg_hit) begin
            dst_leaf[cfg_slot] <= cfg_leaf;
            dst_port[cfg_slot] <= cfg_port;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dst_ok <= '0;
            rr_ptr <= '0;
            dout   <= '0;
            for (int i = 0; i < `LEAF_NUM_OUT; i++) begin
                tags[i] <= '0;
            end
        end else begin
            if (cfg_hit) begin
                dst_ok[cfg_slot] <= 1'b1;
            end
            // During resend the last packet stays put and goes out after release
            if (!resend) begin
                dout <= send ? pkt : '0;
            end
            if (send) begin
                tags[sel] <= tags[sel] + 1'b1;
                rr_ptr    <= (sel == 3'(`LEAF_NUM_OUT - 1)) ? '0 : sel + 1'b1;
            end
        end
    end

endmodule

// File: rtl/leaf_depacketizer.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_depacketizer #(
    parameter leaf_pkg::leaf_id_t LEAF_ID = 5'd3
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  leaf_pkg::packet_t                      din,
    input  logic [`LEAF_NUM_IN-1:0]                ack_user2interface,
    output leaf_pkg::payload_t [`LEAF_NUM_IN-1:0] dout_leaf_interface2user,
    output logic [`LEAF_NUM_IN-1:0]                vld_interface2user,
    output logic                                   cfg_we,
    output logic [`LEAF_CFG_IDX_BITS-1:0]          cfg_index,
    output leaf_pkg::leaf_id_t                     cfg_leaf,
    output leaf_pkg::port_id_t                     cfg_port
);
    import leaf_pkg::*;

    leaf_id_t                pkt_leaf;
    port_id_t                pkt_port;
    payload_t                pkt_payload;
    logic                    pkt_hit;
    logic [`LEAF_NUM_IN-1:0] q_wr;
    logic [`LEAF_NUM_IN-1:0] q_full;
    logic [`LEAF_NUM_IN-1:0] q_empty;

    assign pkt_leaf    = din[`LEAF_DST_LEAF_MSB:`LEAF_DST_LEAF_LSB];
    assign pkt_port    = din[`LEAF_DST_PORT_MSB:`LEAF_DST_PORT_LSB];
    assign pkt_payload = din[`LEAF_PAYLOAD_MSB:`LEAF_PAYLOAD_LSB];
    assign pkt_hit     = din[`LEAF_VALID_BIT] && (pkt_leaf == LEAF_ID);

    // Port 0 carries destination-table writes
    assign cfg_we    = pkt_hit && (pkt_port == '0);
    assign cfg_index = pkt_payload[`LEAF_CFG_IDX_MSB:`LEAF_CFG_IDX_LSB];
    assign cfg_leaf  = pkt_payload[`LEAF_CFG_LEAF_MSB:`LEAF_CFG_LEAF_LSB];
    assign cfg_port  = pkt_payload[`LEAF_CFG_PORT_MSB:`LEAF_CFG_PORT_LSB];

    for (genvar i = 0; i < `LEAF_NUM_IN; i++) begin : g_in
        // Queue i serves network port i+1, other ports fall through and are dropped
        assign q_wr[i] = pkt_hit && (pkt_port == port_id_t'(i + 1)) && !q_full[i];

        leaf_fifo #(
            .DEPTH(`LEAF_FIFO_DEPTH)
        ) i_in_fifo (
            .clk    (clk),
            .rst_n  (rst_n),
            .wr_en  (q_wr[i]),
            .wr_data(pkt_payload),
            .full   (q_full[i]),
            .rd_en  (ack_user2interface[i]),
            .rd_data(dout_leaf_interface2user[i]),
            .empty  (q_empty[i])
        );

        assign vld_interface2user[i] = !q_empty[i];
    end

endmodule

// File: rtl/leaf_fifo.sv
`timescale 1ns/1ps
`include "leaf_consts.svh"

module leaf_fifo #(
    parameter int DEPTH = `LEAF_FIFO_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               wr_en,
    input  leaf_pkg::payload_t wr_data,
    output logic               full,
    input  logic               rd_en,
    output leaf_pkg::payload_t rd_data,
    output logic               empty
);
    import leaf_pkg::*;

    localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_BITS = $clog2(DEPTH + 1);

    payload_t            mem [DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                do_wr;
    logic                do_rd;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] p);
        return (p == PTR_BITS'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full    = (count == CNT_BITS'(DEPTH));
    assign empty   = (count == '0);
    assign do_wr   = wr_en && !full;   // A write into a full queue is lost
    assign do_rd   = rd_en && !empty;
    assign rd_data = mem[rd_ptr];      // Head word is visible without a read

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_rd) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_wr && !do_rd) begin
                count <= count + 1'b1;
            end else if (do_rd && !do_wr) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: rtl/leaf_pkg.sv
`include "leaf_consts.svh"

package leaf_pkg;

    typedef logic [`LEAF_PACKET_BITS-1:0]  packet_t;   // Valid, leaf, port, tag, payload
    typedef logic [`LEAF_PAYLOAD_BITS-1:0] payload_t;
    typedef logic [`LEAF_LEAF_BITS-1:0]    leaf_id_t;
    typedef logic [`LEAF_PORT_BITS-1:0]    port_id_t;
    typedef logic [`LEAF_TAG_BITS-1:0]     tag_t;      // Wraps modulo 128

    // One derived word is emitted per EMIT state
    typedef enum logic [1:0] {
        IDLE,
        EMIT_A,
        EMIT_B,
        EMIT_C
    } kernel_state_t;

endpackage

// File: rtl/leaf_consts.svh
`ifndef LEAF_CONSTS_SVH
`define LEAF_CONSTS_SVH

`define LEAF_PACKET_BITS    49
`define LEAF_PAYLOAD_BITS   32
`define LEAF_LEAF_BITS      5
`define LEAF_PORT_BITS      4
`define LEAF_TAG_BITS       7
`define LEAF_NUM_IN         2
`define LEAF_NUM_OUT        6
`define LEAF_FIFO_DEPTH     8

`define LEAF_VALID_BIT      48
`define LEAF_DST_LEAF_MSB   47
`define LEAF_DST_LEAF_LSB   43
`define LEAF_DST_PORT_MSB   42
`define LEAF_DST_PORT_LSB   39
`define LEAF_TAG_MSB        38
`define LEAF_TAG_LSB        32
`define LEAF_PAYLOAD_MSB    31
`define LEAF_PAYLOAD_LSB    0

`define LEAF_CFG_IDX_BITS   3
`define LEAF_CFG_IDX_MSB    2
`define LEAF_CFG_IDX_LSB    0
`define LEAF_CFG_LEAF_MSB   8
`define LEAF_CFG_LEAF_LSB   4
`define LEAF_CFG_PORT_MSB   12
`define LEAF_CFG_PORT_LSB   9

`endif
